// File: cpc_rom_loader.f
design/cpc_loader_pkg.sv
design/loader_ctrl.sv
design/ext_page_decode.sv
design/rom_addr_map.sv
design/rom_map_tracker.sv
design/cpc_rom_loader.sv
tests/cpc_rom_loader_checker.sv
tests/cpc_rom_loader_tb.sv

// File: Makefile
TOP = cpc_rom_loader_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f cpc_rom_loader.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f cpc_rom_loader.f
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log || (echo "No pass line in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: tests/cpc_rom_loader_tb.sv
// ROM loader testbench
`timescale 1ns/10ps
`default_nettype none

module cpc_rom_loader_tb
	import cpc_loader_pkg::*;
();

	localparam int wait_limit = 40;
	localparam logic [page_w-1:0] sys_pages [4] = '{page_os, page_basic, page_amsdos, page_mf2};

	logic     clk_sys;
	logic     reset;
	dl_info_t dl;
	dl_beat_t dl_beat;
	logic     dl_wr;
	logic     dl_wait;
	logic     mem_wr;
	mem_cmd_t mem_cmd;
	logic     mem_ready;
	logic [rom_pages-1:0] rom_map;

	integer   seed = 32'h987e_5dac;
	int       stall = 0;
	int       stall_cycles = 0;
	int       errors = 0;
	int       failed = 0;
	int       tests = 0;
	int       last_wait = 0;
	bit       hung = 1'b0;
	logic [page_w-1:0] model_base = '0;
	logic     model_combo = 1'b0;
	mem_cmd_t writes[$];
	mem_cmd_t expected[$];

	cpc_rom_loader dut_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl        (dl),
		.dl_beat   (dl_beat),
		.dl_wr     (dl_wr),
		.dl_wait   (dl_wait),
		.mem_wr    (mem_wr),
		.mem_cmd   (mem_cmd),
		.mem_ready (mem_ready),
		.rom_map   (rom_map)
	);

	always #10 clk_sys = ~clk_sys;

	// Memory with 0 to 3 stall cycles per write
	always @(posedge clk_sys) begin
		if (mem_wr && mem_ready) begin
			writes.push_back(mem_cmd);
			stall = $unsigned($random(seed)) % 4;
		end else if (mem_wr && stall != 0) begin
			stall = stall - 1;
			stall_cycles++;
		end
		#1;
		mem_ready = (stall == 0);
	end

	//////////////////////////////////////////////////
	// Expected writes from the slot and page rules
	//////////////////////////////////////////////////

	task automatic predict(input logic [dl_addr_w-1:0] addr, input logic [7:0] data);
		logic [10:0] slot;
		mem_cmd_t    c;
		slot   = addr[24:14];
		c.data = data;
		if (dl.index == 8'd0) begin
			// Slot 8 and above writes nothing
			if (slot <= 11'd7) begin
				c.addr.flat = {sys_pages[slot[1:0]], addr[13:0]};
				c.bank      = (slot >= 11'd4) ? 2'd1 : 2'd0;
				expected.push_back(c);
			end
		end else begin
			c.addr.paged.high   = model_base[8];
			c.addr.paged.page   = model_base[7:0] + addr[21:14];
			c.addr.paged.offset = addr[13:0];
			c.bank = (dl.index[7:6] == 2'b11) ? 2'd1 : 2'd0;
			expected.push_back(c);
			if (c.bank == 2'd0 && (dl.index[7:6] == 2'b01 || dl.index[5:0] != 6'd0)) begin
				c.bank = 2'd1;
				expected.push_back(c);
			end
			// Second page of a combined file moves to the high half
			if (model_combo && addr[13:0] == 14'h3FFF) begin
				model_base  = page_combo_rest;
				model_combo = 1'b0;
			end
		end
	endtask

	task automatic send_byte(input logic [dl_addr_w-1:0] addr, input logic [7:0] data);
		mem_cmd_t got;
		mem_cmd_t exp;
		if (!hung) begin
			predict(addr, data);
			dl_beat.addr = addr;
			dl_beat.data = data;
			dl_wr = 1'b1;
			@(posedge clk_sys);
			#1;
			dl_wr = 1'b0;
			assert (dl_wait && (mem_wr == (expected.size() != 0))) else begin
				$display("Mismatch at %0t: dl_wait/mem_wr got %b/%b expected 1/%b",
					$time, dl_wait, mem_wr, expected.size() != 0);
				errors++;
			end
			last_wait = 0;
			while (dl_wait && last_wait < wait_limit) begin
				@(posedge clk_sys);
				#1;
				last_wait++;
			end
			if (dl_wait) begin
				$display("Timeout at %0t: dl_wait never fell after a beat", $time);
				hung = 1'b1;
				errors++;
			end
			assert (writes.size() == expected.size()) else begin
				$display("Mismatch at %0t: write count got %0d expected %0d",
					$time, writes.size(), expected.size());
				errors++;
			end
			while (writes.size() != 0 && expected.size() != 0) begin
				got = writes.pop_front();
				exp = expected.pop_front();
				assert (got == exp) else begin
					$display("Mismatch at %0t: mem_cmd got %h/%0d/%h expected %h/%0d/%h",
						$time, got.addr.flat, got.bank, got.data,
						exp.addr.flat, exp.bank, exp.data);
					errors++;
				end
			end
			writes.delete();
			expected.delete();
		end
	endtask

	// Drop the active flag, then raise it with the new file
	task automatic start_download(input logic [7:0] index, input logic [15:0] ext,
		input logic [page_w-1:0] base, input logic combo);
		dl.active = 1'b0;
		@(posedge clk_sys);
		#1;
		dl.index    = index;
		dl.ext      = ext;
		dl.active   = 1'b1;
		model_base  = base;
		model_combo = combo;
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_map(input logic [7:0] page);
		assert (rom_map[page] || hung) else begin
			$display("Mismatch at %0t: rom_map[%h] got 0 expected 1", $time, page);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int mark);
		tests++;
		if (errors != mark) begin
			failed++;
		end
		$display("Test %0d %s: %s, %0d errors", tests, name,
			(errors == mark) ? "passed" : "failed", errors - mark);
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		int mark;
		int s;
		clk_sys   = 1'b0;
		reset     = 1'b1;
		dl        = '0;
		dl_beat   = '0;
		dl_wr     = 1'b0;
		mem_ready = 1'b0;
		repeat (4) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		mark = errors;
		assert (!dl_wait && !mem_wr && rom_map == '0) else begin
			$display("Mismatch at %0t: dl_wait/mem_wr/rom_map got %b/%b/%h expected 0/0/0",
				$time, dl_wait, mem_wr, rom_map);
			errors++;
		end
		start_download(8'h00, 16'h0000, '0, 1'b0);
		for (s = 0; s < 8; s++) begin
			send_byte({11'(s), 14'($random(seed))}, 8'($random(seed)));
		end
		// BASIC and AMSDOS sit in the high half
		check_map(8'h00);
		check_map(8'h07);
		finish_test("system slots", mark);

		mark = errors;
		send_byte({11'd8, 14'h0040}, 8'h5A);
		assert (last_wait == 1 || hung) else begin
			$display("Mismatch at %0t: dl_wait cycles got %0d expected 1", $time, last_wait);
			errors++;
		end
		finish_test("unmapped slot", mark);

		mark = errors;
		start_download(8'h40, "1C", 9'h11C, 1'b0);
		send_byte(25'h0, 8'h11);
		send_byte(25'h1234, 8'h22);
		send_byte(25'h3FFF, 8'h33);
		check_map(8'h1C);
		finish_test("expansion 1C", mark);

		mark = errors;
		start_download(8'hC0, "Z0", 9'h000, 1'b1);
		send_byte(25'h0, 8'h44);
		send_byte(25'h3FFF, 8'h55);
		send_byte(25'h4000, 8'h66);
		send_byte(25'h4001, 8'h77);
		finish_test("combined Z0", mark);

		mark = errors;
		start_download(8'h01, "QQ", 9'h1EE, 1'b0);
		send_byte(25'h10, 8'h88);
		send_byte(25'h4020, 8'h99);
		check_map(8'hEE);
		finish_test("bad extension", mark);

		mark = errors;
		assert (stall_cycles > 0) else begin
			$display("The memory model never stalled a write");
			errors++;
		end
		finish_test("back-pressure", mark);

		$display("Tests run: %0d, failed: %0d, errors: %0d", tests, failed, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/cpc_rom_loader_checker.sv
// Loader protocol assertions
`timescale 1ns/10ps
`default_nettype none

module cpc_rom_loader_checker
	import cpc_loader_pkg::*;
(
	input wire           clk_sys,
	input wire           reset,
	input wire           dl_wait,
	input wire           mem_wr,
	input wire mem_cmd_t mem_cmd,
	input wire           mem_ready
);

	// Command holds while memory stalls
	cmd_stable_a: assert property (
		@(posedge clk_sys) disable iff (reset)
		(mem_wr && !mem_ready) |=> (mem_wr && $stable(mem_cmd))
	) else $error("mem_cmd changed or mem_wr dropped under back-pressure");

	// Host is held off for as long as a write is pending
	wait_with_wr_a: assert property (
		@(posedge clk_sys) disable iff (reset)
		mem_wr |-> dl_wait
	) else $error("mem_wr high while dl_wait is low");

	// No write leaves the loader out of a reset cycle
	reset_quiet_a: assert property (
		@(posedge clk_sys) reset |=> !mem_wr
	) else $error("mem_wr high after a reset cycle");

endmodule

bind cpc_rom_loader cpc_rom_loader_checker checker_i (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.dl_wait   (dl_wait),
	.mem_wr    (mem_wr),
	.mem_cmd   (mem_cmd),
	.mem_ready (mem_ready)
);

`default_nettype wire

// File: design/cpc_rom_loader.sv
// CPC ROM image loader top
`timescale 1ns/10ps
`default_nettype none

module cpc_rom_loader
	import cpc_loader_pkg::*;
(
	input  wire      clk_sys,
	input  wire      reset,
	input  wire dl_info_t dl,
	input  wire dl_beat_t dl_beat,
	input  wire      dl_wr,
	output logic     dl_wait,
	output logic     mem_wr,
	output mem_cmd_t mem_cmd,
	input  wire      mem_ready,
	output logic [rom_pages-1:0] rom_map
);

	logic              start;
	logic              byte_done;
	logic              slot_ok;
	logic              write_done;
	logic [page_w-1:0] page_base;
	dl_beat_t          beat;
	mem_cmd_t          cmd;

	loader_ctrl ctrl_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl         (dl),
		.dl_beat    (dl_beat),
		.dl_wr      (dl_wr),
		.dl_wait    (dl_wait),
		.start      (start),
		.byte_done  (byte_done),
		.beat       (beat),
		.cmd        (cmd),
		.slot_ok    (slot_ok),
		.mem_wr     (mem_wr),
		.mem_cmd    (mem_cmd),
		.mem_ready  (mem_ready),
		.write_done (write_done)
	);

	ext_page_decode page_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl        (dl),
		.start     (start),
		.byte_done (byte_done),
		.beat      (beat),
		.page_base (page_base)
	);

	rom_addr_map map_i (
		.beat      (beat),
		.dl        (dl),
		.page_base (page_base),
		.cmd       (cmd),
		.slot_ok   (slot_ok)
	);

	// Tracker sees the bank-adjusted command actually written
	rom_map_tracker tracker_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.write_done (write_done),
		.cmd        (mem_cmd),
		.rom_map    (rom_map)
	);

endmodule

`default_nettype wire

// File: design/rom_map_tracker.sv
// High ROM page map
`timescale 1ns/10ps
`default_nettype none

module rom_map_tracker
	import cpc_loader_pkg::*;
(
	input  wire      clk_sys,
	input  wire      reset,
	input  wire      write_done,
	input  wire mem_cmd_t cmd,
	output logic [rom_pages-1:0] rom_map
);

	// Bits stay set until reset, low half writes are ignored
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_map <= '0;
		end else if (write_done && cmd.addr.paged.high) begin
			rom_map[cmd.addr.paged.page] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: design/rom_addr_map.sv
// Download beat to memory command
`timescale 1ns/10ps
`default_nettype none

module rom_addr_map
	import cpc_loader_pkg::*;
(
	input  wire dl_beat_t beat,
	input  wire dl_info_t dl,
	input  wire [page_w-1:0] page_base,
	output mem_cmd_t cmd,
	output logic     slot_ok
);

	logic [dl_addr_w-offset_w-1:0] slot;
	logic [page_w-1:0]             sys_page;

	assign slot = beat.addr[dl_addr_w-1:offset_w];

	//////////////////////////////////////////////////
	// System ROM slots, 0-3 for the 6128, 4-7 for the 664
	//////////////////////////////////////////////////

	always_comb begin
		sys_page = page_os;
		slot_ok  = 1'b1;
		case (slot)
			11'd0, 11'd4: sys_page = page_os;
			11'd1, 11'd5: sys_page = page_basic;
			11'd2, 11'd6: sys_page = page_amsdos;
			11'd3, 11'd7: sys_page = page_mf2;
			default: begin
				slot_ok = 1'b0;
			end
		endcase
		// Expansion files always map
		if (dl.index != 8'd0) begin
			slot_ok = 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Command
	//////////////////////////////////////////////////

	always_comb begin
		cmd.data = beat.data;
		if (dl.index == 8'd0) begin
			cmd.addr.flat = {sys_page, beat.addr[offset_w-1:0]};
			cmd.bank      = {1'b0, slot[2]};
		end else begin
			cmd.addr.paged.high   = page_base[page_w-1];
			// Page wraps within 8 bits
			cmd.addr.paged.page   = page_base[7:0] + beat.addr[21:14];
			cmd.addr.paged.offset = beat.addr[offset_w-1:0];
			cmd.bank              = {1'b0, &dl.index[7:6]};
		end
	end

endmodule

`default_nettype wire

// File: design/ext_page_decode.sv
// Expansion ROM page decode
`timescale 1ns/10ps
`default_nettype none

module ext_page_decode
	import cpc_loader_pkg::*;
(
	input  wire      clk_sys,
	input  wire      reset,
	input  wire dl_info_t dl,
	input  wire      start,
	input  wire      byte_done,
	input  wire dl_beat_t beat,
	output logic [page_w-1:0] page_base
);

	logic              combo;
	logic [4:0]        hi_digit;
	logic [4:0]        lo_digit;
	logic              ext_z0;
	logic [page_w-1:0] ext_page;

	// Top bit flags a valid hex digit, low nibble is its value
	function automatic logic [4:0] hex_digit(input logic [7:0] ch);
		logic [4:0] res;
		res = 5'd0;
		if (ch >= "0" && ch <= "9") begin
			res = {1'b1, ch[3:0]};
		end else if (ch >= "A" && ch <= "F") begin
			res = {1'b1, ch[3:0] + 4'd9};
		end
		return res;
	endfunction

	//////////////////////////////////////////////////
	// Extension to page
	//////////////////////////////////////////////////

	always_comb begin
		hi_digit = hex_digit(dl.ext[15:8]);
		lo_digit = hex_digit(dl.ext[7:0]);
		ext_z0   = (dl.ext == "Z0");
		ext_page = page_bad_ext;
		if (hi_digit[4]) begin
			ext_page[7:4] = hi_digit[3:0];
		end
		if (lo_digit[4]) begin
			ext_page[3:0] = lo_digit[3:0];
		end
		// ZZ and Z0 start at low page 0
		if ((dl.ext == "ZZ") || ext_z0) begin
			ext_page = '0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_base <= '0;
			combo     <= 1'b0;
		end else if (start) begin
			combo <= 1'b0;
			// Index 0 uses the fixed system slots instead
			if (dl.index != 8'd0) begin
				page_base <= ext_page;
				combo     <= ext_z0;
			end
		end else if (byte_done && combo && (&beat.addr[offset_w-1:0])) begin
			// First page of a combined file done, rest goes high
			page_base <= page_combo_rest;
			combo     <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: design/loader_ctrl.sv
// Download and memory write control
`timescale 1ns/10ps
`default_nettype none

module loader_ctrl
	import cpc_loader_pkg::*;
(
	input  wire      clk_sys,
	input  wire      reset,

	// Host download side
	input  wire dl_info_t dl,
	input  wire dl_beat_t dl_beat,
	input  wire      dl_wr,
	output logic     dl_wait,

	// Page decode handshake
	output logic     start,
	output logic     byte_done,

	// Address map, works on the latched beat
	output dl_beat_t beat,
	input  wire mem_cmd_t cmd,
	input  wire      slot_ok,

	// Memory side
	output logic     mem_wr,
	output mem_cmd_t mem_cmd,
	input  wire      mem_ready,
	output logic     write_done
);

	logic [state_w-1:0] state;
	logic               active_q;
	logic               take;
	logic               copy_bank1;

	//////////////////////////////////////////////////
	// Beat intake
	//////////////////////////////////////////////////

	assign take = dl_wr && !dl_wait;

	always_ff @(posedge clk_sys) begin
		if (take) begin
			beat <= dl_beat;
		end
	end

	// New download starts on the rising edge of the active flag
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active_q <= 1'b0;
		end else begin
			active_q <= dl.active;
		end
	end

	assign start = dl.active && !active_q;

	//////////////////////////////////////////////////
	// Write sequencing
	//////////////////////////////////////////////////

	// Expansion ROMs go to both banks when loaded by hand or as boot.eXX
	assign copy_bank1 = ((dl.index[7:6] == 2'b01) || (dl.index[5:0] != 6'd0))
		&& (cmd.bank == 2'd0);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_write: begin
					if (!slot_ok) begin
						// Unmapped system slot, drop the byte
						state <= st_idle;
					end else if (write_done) begin
						state <= copy_bank1 ? st_bank1 : st_finish;
					end
				end
				st_bank1: begin
					if (write_done) begin
						state <= st_finish;
					end
				end
				default: begin
					// Idle and finish both accept the next beat
					state <= take ? st_write : st_idle;
				end
			endcase
		end
	end

	assign dl_wait    = (state == st_write) || (state == st_bank1);
	assign mem_wr     = ((state == st_write) && slot_ok) || (state == st_bank1);
	assign write_done = mem_wr && mem_ready;

	// Bookkeeping cycle after the last write, beat still holds its offset
	assign byte_done = (state == st_finish);

	always_comb begin
		mem_cmd = cmd;
		if (state == st_bank1) begin
			mem_cmd.bank = 2'd1;
		end
	end

endmodule

`default_nettype wire

// File: design/cpc_loader_pkg.sv
// CPC ROM loader shared definitions
`default_nettype none

package cpc_loader_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	localparam int dl_addr_w  = 25;
	localparam int mem_addr_w = 23;
	localparam int page_w     = 9;
	localparam int offset_w   = 14;
	localparam int rom_pages  = 256;

	//////////////////////////////////////////////////
	// Page constants, top bit selects the high ROM half
	//////////////////////////////////////////////////

	localparam logic [page_w-1:0] page_os         = 9'h000;
	localparam logic [page_w-1:0] page_basic      = 9'h100;
	localparam logic [page_w-1:0] page_amsdos     = 9'h107;
	localparam logic [page_w-1:0] page_mf2        = 9'h0FF;
	// Spare page for files whose extension is not a hex number
	localparam logic [page_w-1:0] page_bad_ext    = 9'h1EE;
	// Wraps to high page 0 on the second page of a combined file
	localparam logic [page_w-1:0] page_combo_rest = 9'h1FF;

	// Loader FSM encoding
	localparam int state_w = 2;
	localparam logic [state_w-1:0] st_idle   = 2'd0;
	localparam logic [state_w-1:0] st_write  = 2'd1;
	localparam logic [state_w-1:0] st_bank1  = 2'd2;
	localparam logic [state_w-1:0] st_finish = 2'd3;

	//////////////////////////////////////////////////
	// Download and memory types
	//////////////////////////////////////////////////

	typedef struct packed {
		logic        active;
		logic [7:0]  index;
		logic [15:0] ext;
	} dl_info_t;

	typedef struct packed {
		logic [dl_addr_w-1:0] addr;
		logic [7:0]           data;
	} dl_beat_t;

	// Page view of a memory address
	typedef struct packed {
		logic                high;
		logic [7:0]          page;
		logic [offset_w-1:0] offset;
	} mem_page_t;

	// Same 23 bits, flat or split into half, page and offset
	typedef union packed {
		logic [mem_addr_w-1:0] flat;
		mem_page_t             paged;
	} mem_addr_u;

	typedef struct packed {
		mem_addr_u  addr;
		logic [1:0] bank;
		logic [7:0] data;
	} mem_cmd_t;

endpackage

`default_nettype wire
